// File: snes_pkg.sv
package snes_pkg;

  // Bus widths on the cartridge connector
  parameter int SNES_ADDR_W = 24;
  parameter int SNES_PA_W   = 8;

  // LoROM view of an address
  // bank in the top byte, 16-bit offset below
  typedef struct packed {
    logic [7:0]  bank;
    logic [15:0] offset;
  } snes_lorom_t;

  // One SNES address, decoded two ways
  // linear for HiROM and the SaveRAM bank range
  // lorom for the LoROM fold and the 8 KB SaveRAM window
  typedef union packed {
    logic [SNES_ADDR_W-1:0] linear;
    snes_lorom_t            lorom;
  } snes_addr_t;

  // Physical base of SaveRAM in the shared memory
  parameter logic [SNES_ADDR_W-1:0] SAVERAM_BASE = 24'hE00000;

  // Service hooks patched into the game
  parameter logic [SNES_ADDR_W-1:0] NMICMD_ADDR        = 24'h002BF2;
  parameter logic [SNES_ADDR_W-1:0] RETURN_VECTOR_ADDR = 24'h002A5A;
  parameter logic [SNES_ADDR_W-1:0] BRANCH1_ADDR       = 24'h002A13;
  parameter logic [SNES_ADDR_W-1:0] BRANCH2_ADDR       = 24'h002A4D;

  // Snescmd page match on {A22, A15..A9}
  // i.e. 00-3F/80-BF:2A00-2BFF
  parameter logic [7:0] SNESCMD_PAGE = 8'b0_0010101;

  // B-bus register 213F
  parameter logic [SNES_PA_W-1:0] PA_213F = 8'h3F;

endpackage

// File: cart_cfg_pkg.sv
package cart_cfg_pkg;

  // AXI4-Lite port widths
  parameter int AXI_ADDR_W = 4;
  parameter int AXI_DATA_W = 32;

  // Register widths
  parameter int FEATURE_W = 8;
  parameter int MASK_W    = 24;

  // Register byte offsets
  parameter logic [AXI_ADDR_W-1:0] REG_FEATURES     = 4'h0;
  parameter logic [AXI_ADDR_W-1:0] REG_ROM_MASK     = 4'h4;
  parameter logic [AXI_ADDR_W-1:0] REG_SAVERAM_MASK = 4'h8;
  // Read only
  parameter logic [AXI_ADDR_W-1:0] REG_ID           = 4'hC;

  // Value returned by REG_ID, ASCII "GSU1"
  parameter logic [AXI_DATA_W-1:0] CART_ID = 32'h4753_5531;

  // Feature bit positions
  parameter logic [2:0] FEAT_MSU1 = 3'd3;
  parameter logic [2:0] FEAT_213F = 3'd4;

  // AXI response codes
  parameter logic [1:0] RESP_OKAY   = 2'b00;
  parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                           CLK,
  input  logic                           rst,
  input  logic [snes_pkg::SNES_ADDR_W-1:0] SNES_ADDR,
  input  logic [snes_pkg::SNES_PA_W-1:0]   SNES_PA,
  input  logic                           SNES_ROMSEL,
  output snes_pkg::snes_addr_t           addr_s,
  output logic [snes_pkg::SNES_PA_W-1:0]   pa_s,
  output logic                           romsel_s
);

  // Flop chains, index 0 samples the pins
  snes_pkg::snes_addr_t                addr_q   [SYNC_STAGES];
  logic [snes_pkg::SNES_PA_W-1:0]      pa_q     [SYNC_STAGES];
  logic                                romsel_q [SYNC_STAGES];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        addr_q[i]   <= '0;
        pa_q[i]     <= '0;
        // ROMSEL idles high
        romsel_q[i] <= 1'b1;
      end
    end else begin
      // First stage may go metastable
      addr_q[0].linear <= SNES_ADDR;
      pa_q[0]          <= SNES_PA;
      romsel_q[0]      <= SNES_ROMSEL;
      // Remaining stages settle it
      for (int i = 1; i < SYNC_STAGES; i++) begin
        addr_q[i]   <= addr_q[i-1];
        pa_q[i]     <= pa_q[i-1];
        romsel_q[i] <= romsel_q[i-1];
      end
    end
  end

  // Last stage feeds the decoder
  assign addr_s   = addr_q[SYNC_STAGES-1];
  assign pa_s     = pa_q[SYNC_STAGES-1];
  assign romsel_s = romsel_q[SYNC_STAGES-1];

endmodule

// File: address.sv
`timescale 1ns/1ps

module address (
  input  logic                                CLK,
  input  logic                                rst,
  input  snes_pkg::snes_addr_t                addr_s,
  input  logic [snes_pkg::SNES_PA_W-1:0]      pa_s,
  input  logic                                romsel_s,
  input  logic [cart_cfg_pkg::FEATURE_W-1:0]  features,
  input  logic [cart_cfg_pkg::MASK_W-1:0]     rom_mask,
  input  logic [cart_cfg_pkg::MASK_W-1:0]     saveram_mask,
  output logic [snes_pkg::SNES_ADDR_W-1:0]    ROM_ADDR,
  output logic                                ROM_HIT,
  output logic                                IS_SAVERAM,
  output logic                                IS_ROM,
  output logic                                IS_WRITABLE,
  output logic                                msu_enable,
  output logic                                r213f_enable,
  output logic                                snescmd_enable,
  output logic                                nmicmd_enable,
  output logic                                return_vector_enable,
  output logic                                branch1_enable,
  output logic                                branch2_enable,
  output logic                                gsu_enable
);

  logic                             a22;
  logic [15:0]                      ofs;
  logic                             is_rom_d;
  logic                             is_saveram_d;
  logic [snes_pkg::SNES_ADDR_W-1:0] saveram_ofs;
  logic [snes_pkg::SNES_ADDR_W-1:0] rom_lin;
  logic [snes_pkg::SNES_ADDR_W-1:0] rom_addr_d;
  logic                             msu_d;
  logic                             r213f_d;
  logic                             gsu_d;

  assign a22 = addr_s.linear[22];
  assign ofs = addr_s.lorom.offset;

  ////////////////////////////////////////
  // Region classification
  ////////////////////////////////////////

  // 40-7F/C0-FF anywhere, or upper half of a LoROM bank
  assign is_rom_d = a22 | ofs[15];

  // Only with SaveRAM enabled and ROMSEL asserted
  // 70-7F/F0-FF whole bank, or 00-3F/80-BF:6000-7FFF
  assign is_saveram_d = saveram_mask[0] & ~romsel_s
                        & ((&addr_s.linear[22:20])
                           | (~a22 & ~ofs[15] & (&ofs[14:13])));

  ////////////////////////////////////////
  // Physical address
  ////////////////////////////////////////

  // Upper banks give 2 MB of offset, the window gives 8 KB
  assign saveram_ofs = a22 ? {3'b000, addr_s.linear[20:0]}
                           : {11'd0, ofs[12:0]};

  // GSU mixes both layouts
  // HiROM linear above bank 40, LoROM fold below
  assign rom_lin = a22 ? {2'b00, addr_s.linear[21:0]}
                       : {2'b00, addr_s.lorom.bank[6:0], ofs[14:0]};

  assign rom_addr_d = is_saveram_d
                      ? snes_pkg::SAVERAM_BASE + (saveram_ofs & saveram_mask)
                      : rom_lin & rom_mask;

  ////////////////////////////////////////
  // Peripheral enables
  ////////////////////////////////////////

  // MSU1 registers at 2000-2007 in system banks
  assign msu_d = features[cart_cfg_pkg::FEAT_MSU1] & ~a22 & (ofs[15:3] == 13'h0400);

  assign r213f_d = features[cart_cfg_pkg::FEAT_213F] & (pa_s == snes_pkg::PA_213F);

  // GSU registers 3000-32FF, 3300-33FF left out
  assign gsu_d = ~a22 & (ofs[15:10] == 6'b001100) & (ofs[9:8] != 2'b11);

  // Single output stage
  always_ff @(posedge CLK) begin
    if (rst) begin
      ROM_ADDR             <= '0;
      ROM_HIT              <= 1'b0;
      IS_SAVERAM           <= 1'b0;
      IS_ROM               <= 1'b0;
      IS_WRITABLE          <= 1'b0;
      msu_enable           <= 1'b0;
      r213f_enable         <= 1'b0;
      snescmd_enable       <= 1'b0;
      nmicmd_enable        <= 1'b0;
      return_vector_enable <= 1'b0;
      branch1_enable       <= 1'b0;
      branch2_enable       <= 1'b0;
      gsu_enable           <= 1'b0;
    end else begin
      ROM_ADDR             <= rom_addr_d;
      ROM_HIT              <= is_rom_d | is_saveram_d;
      IS_SAVERAM           <= is_saveram_d;
      IS_ROM               <= is_rom_d;
      // SaveRAM is the only writable region
      IS_WRITABLE          <= is_saveram_d;
      msu_enable           <= msu_d;
      r213f_enable         <= r213f_d;
      snescmd_enable       <= ({a22, ofs[15:9]} == snes_pkg::SNESCMD_PAGE);
      // exact matches, bank included
      nmicmd_enable        <= (addr_s.linear == snes_pkg::NMICMD_ADDR);
      return_vector_enable <= (addr_s.linear == snes_pkg::RETURN_VECTOR_ADDR);
      branch1_enable       <= (addr_s.linear == snes_pkg::BRANCH1_ADDR);
      branch2_enable       <= (addr_s.linear == snes_pkg::BRANCH2_ADDR);
      gsu_enable           <= gsu_d;
    end
  end

endmodule

// File: cart_config_regs.sv
`timescale 1ns/1ps

module cart_config_regs (
  input  logic                                  CLK,
  input  logic                                  rst,
  input  logic [cart_cfg_pkg::AXI_ADDR_W-1:0]   awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [cart_cfg_pkg::AXI_DATA_W-1:0]   wdata,
  input  logic [cart_cfg_pkg::AXI_DATA_W/8-1:0] wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  output logic [1:0]                            bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  input  logic [cart_cfg_pkg::AXI_ADDR_W-1:0]   araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  output logic [cart_cfg_pkg::AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                            rresp,
  output logic                                  rvalid,
  input  logic                                  rready,
  output logic [cart_cfg_pkg::FEATURE_W-1:0]    features,
  output logic [cart_cfg_pkg::MASK_W-1:0]       rom_mask,
  output logic [cart_cfg_pkg::MASK_W-1:0]       saveram_mask
);

  localparam int DW     = cart_cfg_pkg::AXI_DATA_W;
  localparam int STRB_W = DW / 8;

  logic          wr_fire;
  logic          rd_fire;
  logic [DW-1:0] feat_ext;
  logic [DW-1:0] rom_ext;
  logic [DW-1:0] sram_ext;
  logic [DW-1:0] feat_wr;
  logic [DW-1:0] rom_wr;
  logic [DW-1:0] sram_wr;

  // Byte lane merge of new data into a register
  function automatic logic [DW-1:0] merge_strb(input logic [DW-1:0]     cur,
                                               input logic [DW-1:0]     data,
                                               input logic [STRB_W-1:0] strb);
    logic [DW-1:0] res;
    res = cur;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // Registers as seen on the bus, zero extended
  assign feat_ext = {{(DW - cart_cfg_pkg::FEATURE_W){1'b0}}, features};
  assign rom_ext  = {{(DW - cart_cfg_pkg::MASK_W){1'b0}}, rom_mask};
  assign sram_ext = {{(DW - cart_cfg_pkg::MASK_W){1'b0}}, saveram_mask};

  assign feat_wr = merge_strb(feat_ext, wdata, wstrb);
  assign rom_wr  = merge_strb(rom_ext, wdata, wstrb);
  assign sram_wr = merge_strb(sram_ext, wdata, wstrb);

  // Handshakes complete while the ready pulse is up
  assign wr_fire = awready & awvalid & wvalid;
  assign rd_fire = arready & arvalid;

  ////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      awready      <= 1'b0;
      wready       <= 1'b0;
      bvalid       <= 1'b0;
      features     <= '0;
      rom_mask     <= '1;
      // SaveRAM off until the MCU sets it up
      saveram_mask <= '0;
    end else begin
      // One cycle ready pulse, held off while a response waits
      awready <= awvalid & wvalid & ~awready & ~bvalid;
      wready  <= awvalid & wvalid & ~awready & ~bvalid;
      if (wr_fire) begin
        bvalid <= 1'b1;
        bresp  <= cart_cfg_pkg::RESP_OKAY;
        case (awaddr)
          cart_cfg_pkg::REG_FEATURES:     features     <= feat_wr[cart_cfg_pkg::FEATURE_W-1:0];
          cart_cfg_pkg::REG_ROM_MASK:     rom_mask     <= rom_wr[cart_cfg_pkg::MASK_W-1:0];
          cart_cfg_pkg::REG_SAVERAM_MASK: saveram_mask <= sram_wr[cart_cfg_pkg::MASK_W-1:0];
          // ID register and holes reject writes
          default:                        bresp        <= cart_cfg_pkg::RESP_SLVERR;
        endcase
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= arvalid & ~arready & ~rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
        rresp  <= cart_cfg_pkg::RESP_OKAY;
        case (araddr)
          cart_cfg_pkg::REG_FEATURES:     rdata <= feat_ext;
          cart_cfg_pkg::REG_ROM_MASK:     rdata <= rom_ext;
          cart_cfg_pkg::REG_SAVERAM_MASK: rdata <= sram_ext;
          cart_cfg_pkg::REG_ID:           rdata <= cart_cfg_pkg::CART_ID;
          default: begin
            rdata <= '0;
            rresp <= cart_cfg_pkg::RESP_SLVERR;
          end
        endcase
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

// File: cart_top.sv
`timescale 1ns/1ps

module cart_top #(
  parameter int SYNC_STAGES = 2
) (
  input  logic                                  CLK,
  input  logic                                  rst,
  // MCU configuration port
  input  logic [cart_cfg_pkg::AXI_ADDR_W-1:0]   awaddr,
  input  logic                                  awvalid,
  output logic                                  awready,
  input  logic [cart_cfg_pkg::AXI_DATA_W-1:0]   wdata,
  input  logic [cart_cfg_pkg::AXI_DATA_W/8-1:0] wstrb,
  input  logic                                  wvalid,
  output logic                                  wready,
  output logic [1:0]                            bresp,
  output logic                                  bvalid,
  input  logic                                  bready,
  input  logic [cart_cfg_pkg::AXI_ADDR_W-1:0]   araddr,
  input  logic                                  arvalid,
  output logic                                  arready,
  output logic [cart_cfg_pkg::AXI_DATA_W-1:0]   rdata,
  output logic [1:0]                            rresp,
  output logic                                  rvalid,
  input  logic                                  rready,
  // SNES cartridge bus, asynchronous
  input  logic [snes_pkg::SNES_ADDR_W-1:0]      SNES_ADDR,
  input  logic [snes_pkg::SNES_PA_W-1:0]        SNES_PA,
  input  logic                                  SNES_ROMSEL,
  // Decode results
  output logic [snes_pkg::SNES_ADDR_W-1:0]      ROM_ADDR,
  output logic                                  ROM_HIT,
  output logic                                  IS_SAVERAM,
  output logic                                  IS_ROM,
  output logic                                  IS_WRITABLE,
  output logic                                  msu_enable,
  output logic                                  r213f_enable,
  output logic                                  snescmd_enable,
  output logic                                  nmicmd_enable,
  output logic                                  return_vector_enable,
  output logic                                  branch1_enable,
  output logic                                  branch2_enable,
  output logic                                  gsu_enable
);

  logic [cart_cfg_pkg::FEATURE_W-1:0] features;
  logic [cart_cfg_pkg::MASK_W-1:0]    rom_mask;
  logic [cart_cfg_pkg::MASK_W-1:0]    saveram_mask;
  snes_pkg::snes_addr_t               addr_s;
  logic [snes_pkg::SNES_PA_W-1:0]     pa_s;
  logic                               romsel_s;

  // Feature bits and masks from the MCU
  cart_config_regs u_cfg (
    .CLK          (CLK),
    .rst          (rst),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bresp        (bresp),
    .bvalid       (bvalid),
    .bready       (bready),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rresp        (rresp),
    .rvalid       (rvalid),
    .rready       (rready),
    .features     (features),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask)
  );

  // Bring the SNES pins into the CLK domain
  snes_bus_sync #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_sync (
    .CLK         (CLK),
    .rst         (rst),
    .SNES_ADDR   (SNES_ADDR),
    .SNES_PA     (SNES_PA),
    .SNES_ROMSEL (SNES_ROMSEL),
    .addr_s      (addr_s),
    .pa_s        (pa_s),
    .romsel_s    (romsel_s)
  );

  // Map and enables, one register stage
  address u_address (
    .CLK                  (CLK),
    .rst                  (rst),
    .addr_s               (addr_s),
    .pa_s                 (pa_s),
    .romsel_s             (romsel_s),
    .features             (features),
    .rom_mask             (rom_mask),
    .saveram_mask         (saveram_mask),
    .ROM_ADDR             (ROM_ADDR),
    .ROM_HIT              (ROM_HIT),
    .IS_SAVERAM           (IS_SAVERAM),
    .IS_ROM               (IS_ROM),
    .IS_WRITABLE          (IS_WRITABLE),
    .msu_enable           (msu_enable),
    .r213f_enable         (r213f_enable),
    .snescmd_enable       (snescmd_enable),
    .nmicmd_enable        (nmicmd_enable),
    .return_vector_enable (return_vector_enable),
    .branch1_enable       (branch1_enable),
    .branch2_enable       (branch2_enable),
    .gsu_enable           (gsu_enable)
  );

endmodule

// File: tb_cart_top.sv
`timescale 1ns/1ps

module tb_cart_top;

  localparam int N_RAND = 100;
  // Stimulus runs about 1200 cycles so the limit leaves a wide margin
  localparam int TIMEOUT_CYCLES = 4000;
  // Service hooks with neighbours, snescmd and GSU edges, bank mirrors
  localparam logic [23:0] EDGE_ADDRS [23] = '{
    24'h002BF1, 24'h002BF2, 24'h002BF3, 24'h002A59, 24'h002A5A, 24'h002A5B,
    24'h002A12, 24'h002A13, 24'h002A14, 24'h002A4C, 24'h002A4D, 24'h002A4E,
    24'h0029FF, 24'h002A00, 24'h002BFF, 24'h002C00, 24'h002FFF, 24'h003000,
    24'h0032FF, 24'h003300, 24'h802BF2, 24'h402A00, 24'h403000
  };

  logic        CLK;
  logic        rst;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [23:0] SNES_ADDR;
  logic [7:0]  SNES_PA;
  logic        SNES_ROMSEL;
  logic [23:0] ROM_ADDR;
  logic        ROM_HIT;
  logic        IS_SAVERAM;
  logic        IS_ROM;
  logic        IS_WRITABLE;
  logic        msu_enable;
  logic        r213f_enable;
  logic        snescmd_enable;
  logic        nmicmd_enable;
  logic        return_vector_enable;
  logic        branch1_enable;
  logic        branch2_enable;
  logic        gsu_enable;

  int          errors;
  int          cycles;
  int          seed;
  logic [31:0] r;
  logic [31:0] r2;
  logic [23:0] a;
  logic [31:0] rd_data;
  logic [1:0]  rd_resp;
  // Shadow of what was written over AXI
  logic        cfg_busy;
  logic [7:0]  cfg_features;
  logic [23:0] cfg_rom_mask;
  logic [23:0] cfg_sram_mask;
  // Expected decode, delayed to match the DUT latency
  logic [35:0] exp_pipe [3];
  logic        chk_pipe [3];
  logic [23:0] exp_addr;
  logic [3:0]  exp_flags;
  logic [7:0]  exp_en;
  logic [3:0]  dut_flags;
  logic [7:0]  dut_en;

  cart_top #(
    .SYNC_STAGES (2)
  ) DUT (.*);

  initial CLK = 1'b0;
  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] merge_lanes(input logic [31:0] cur,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // {phys addr, rom_hit, saveram, rom, writable, 8 enables}
  function automatic logic [35:0] expect_decode(input logic [23:0] ad,
                                                input logic [7:0]  pa,
                                                input logic        rs);
    logic [7:0]  bank;
    logic [15:0] ofs;
    logic        rom;
    logic        upper;
    logic        win;
    logic        sram;
    logic [23:0] phys;
    logic [7:0]  en;
    bank  = ad[23:16];
    ofs   = ad[15:0];
    rom   = ad[22] || (ofs >= 16'h8000);
    upper = (bank >= 8'h70 && bank <= 8'h7F) || (bank >= 8'hF0);
    win   = (bank <= 8'h3F || (bank >= 8'h80 && bank <= 8'hBF))
            && ofs >= 16'h6000 && ofs <= 16'h7FFF;
    sram  = cfg_sram_mask[0] && !rs && (upper || win);
    if (sram && upper) begin
      phys = snes_pkg::SAVERAM_BASE + ({3'b000, ad[20:0]} & cfg_sram_mask);
    end else if (sram) begin
      phys = snes_pkg::SAVERAM_BASE + (24'(ofs - 16'h6000) & cfg_sram_mask);
    end else if (ad[22]) begin
      phys = {2'b00, ad[21:0]} & cfg_rom_mask;
    end else begin
      // 32 KB LoROM banks stacked back to back
      phys = (24'(bank[6:0]) * 24'h8000 + 24'(ofs[14:0])) & cfg_rom_mask;
    end
    en[7] = cfg_features[cart_cfg_pkg::FEAT_MSU1] && !ad[22]
            && ofs >= 16'h2000 && ofs <= 16'h2007;
    en[6] = cfg_features[cart_cfg_pkg::FEAT_213F] && pa == 8'h3F;
    en[5] = !ad[22] && ofs >= 16'h2A00 && ofs <= 16'h2BFF;
    en[4] = ad == snes_pkg::NMICMD_ADDR;
    en[3] = ad == snes_pkg::RETURN_VECTOR_ADDR;
    en[2] = ad == snes_pkg::BRANCH1_ADDR;
    en[1] = ad == snes_pkg::BRANCH2_ADDR;
    en[0] = !ad[22] && ofs >= 16'h3000 && ofs <= 16'h32FF;
    return {phys, rom || sram, sram, rom, sram, en};
  endfunction

  // Pins seen here enter the synchronizer on this same edge
  always @(posedge CLK) begin
    exp_pipe[0] <= expect_decode(SNES_ADDR, SNES_PA, SNES_ROMSEL);
    chk_pipe[0] <= !rst && !cfg_busy;
    for (int i = 1; i < 3; i++) begin
      exp_pipe[i] <= exp_pipe[i-1];
      chk_pipe[i] <= chk_pipe[i-1];
    end
  end

  assign exp_addr  = exp_pipe[2][35:12];
  assign exp_flags = exp_pipe[2][11:8];
  assign exp_en    = exp_pipe[2][7:0];
  assign dut_flags = {ROM_HIT, IS_SAVERAM, IS_ROM, IS_WRITABLE};
  assign dut_en    = {msu_enable, r213f_enable, snescmd_enable, nmicmd_enable,
                      return_vector_enable, branch1_enable, branch2_enable, gsu_enable};

  ////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////

  rom_addr_chk: assert property (@(posedge CLK) disable iff (!chk_pipe[2])
                                 ROM_ADDR == exp_addr)
    else begin
      errors++;
      $display("FAILED at %0t: ROM_ADDR %h, expected %h", $time,
               $sampled(ROM_ADDR), $sampled(exp_addr));
    end

  region_chk: assert property (@(posedge CLK) disable iff (!chk_pipe[2])
                               dut_flags == exp_flags)
    else begin
      errors++;
      $display("FAILED at %0t: region flags %b, expected %b", $time,
               $sampled(dut_flags), $sampled(exp_flags));
    end

  enable_chk: assert property (@(posedge CLK) disable iff (!chk_pipe[2])
                               dut_en == exp_en)
    else begin
      errors++;
      $display("FAILED at %0t: enables %b, expected %b", $time,
               $sampled(dut_en), $sampled(exp_en));
    end

  // Write response follows the handshake by one cycle
  wr_resp_chk: assert property (@(posedge CLK) disable iff (rst)
                                (awready && awvalid && wvalid) |=> bvalid)
    else begin
      errors++;
      $display("FAILED at %0t: bvalid missing after write handshake", $time);
    end

  // Read data follows the address handshake by one cycle
  rd_resp_chk: assert property (@(posedge CLK) disable iff (rst)
                                (arready && arvalid) |=> rvalid)
    else begin
      errors++;
      $display("FAILED at %0t: rvalid missing after read handshake", $time);
    end

  // Run limit
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  task automatic drive_bus(input logic [23:0] ad, input logic [7:0] pa, input logic rs);
    @(posedge CLK);
    SNES_ADDR   <= ad;
    SNES_PA     <= pa;
    SNES_ROMSEL <= rs;
  endtask

  task automatic axi_write(input logic [3:0] ad, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [1:0]  exp_resp;
    logic [31:0] merged;
    exp_resp = cart_cfg_pkg::RESP_SLVERR;
    @(posedge CLK);
    // Decode checks pause around a config change
    cfg_busy <= 1'b1;
    awaddr   <= ad;
    awvalid  <= 1'b1;
    wdata    <= data;
    wstrb    <= strb;
    wvalid   <= 1'b1;
    bready   <= 1'b1;
    do @(posedge CLK); while (!awready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    do @(posedge CLK); while (!bvalid);
    bready <= 1'b0;
    case (ad)
      cart_cfg_pkg::REG_FEATURES: begin
        merged       = merge_lanes({24'd0, cfg_features}, data, strb);
        cfg_features <= merged[7:0];
        exp_resp     = cart_cfg_pkg::RESP_OKAY;
      end
      cart_cfg_pkg::REG_ROM_MASK: begin
        merged       = merge_lanes({8'd0, cfg_rom_mask}, data, strb);
        cfg_rom_mask <= merged[23:0];
        exp_resp     = cart_cfg_pkg::RESP_OKAY;
      end
      cart_cfg_pkg::REG_SAVERAM_MASK: begin
        merged        = merge_lanes({8'd0, cfg_sram_mask}, data, strb);
        cfg_sram_mask <= merged[23:0];
        exp_resp      = cart_cfg_pkg::RESP_OKAY;
      end
      default: ;
    endcase
    assert (bresp == exp_resp)
      else begin
        errors++;
        $display("FAILED at %0t: write to %h gave bresp %b", $time, ad, bresp);
      end
    repeat (4) @(posedge CLK);
    cfg_busy <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] ad, output logic [31:0] data,
                          output logic [1:0] resp);
    @(posedge CLK);
    araddr  <= ad;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    do @(posedge CLK); while (!arready);
    arvalid <= 1'b0;
    do @(posedge CLK); while (!rvalid);
    rready <= 1'b0;
    data = rdata;
    resp = rresp;
  endtask

  // Data only matters on an OKAY response
  task automatic read_check(input logic [3:0] ad, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
    axi_read(ad, rd_data, rd_resp);
    assert (rd_resp == exp_resp && (exp_resp != 2'b00 || rd_data == exp_data))
      else begin
        errors++;
        $display("FAILED at %0t: read %h gave %h/%b, expected %h/%b", $time,
                 ad, rd_data, rd_resp, exp_data, exp_resp);
      end
  endtask

  ////////////////////////////////////////
  // Stimulus sweeps
  ////////////////////////////////////////

  // HiROM or LoROM upper half, chosen at random
  task automatic rom_sweep();
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      a = r[23:0];
      if (r[31]) begin
        a[22] = 1'b1;
      end else begin
        a[22] = 1'b0;
        a[15] = 1'b1;
      end
      drive_bus(a, r[31:24], 1'b0);
    end
  endtask

  // Upper banks or the 6000-7FFF window
  task automatic saveram_sweep(input logic rs);
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      a = r[23:0];
      if (r[31]) begin
        a[22:20] = 3'b111;
      end else begin
        a[22]    = 1'b0;
        a[15:13] = 3'b011;
      end
      drive_bus(a, 8'h00, rs);
    end
  endtask

  task automatic feature_sweep();
    for (int o = 16'h1FFE; o <= 16'h2008; o++) begin
      drive_bus({8'h00, 16'(o)}, 8'h00, 1'b1);
      drive_bus({8'h40, 16'(o)}, 8'h00, 1'b1);
    end
    for (int p = 8'h3E; p <= 8'h40; p++) begin
      drive_bus(24'h008000, 8'(p), 1'b1);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    errors        = 0;
    cycles        = 0;
    seed          = 60682;
    rst           = 1'b1;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    SNES_ADDR     = '0;
    SNES_PA       = '0;
    SNES_ROMSEL   = 1'b1;
    cfg_busy      = 1'b0;
    cfg_features  = 8'h00;
    cfg_rom_mask  = 24'hFFFFFF;
    cfg_sram_mask = 24'h000000;
    for (int i = 0; i < 3; i++) begin
      chk_pipe[i] = 1'b0;
      exp_pipe[i] = '0;
    end
    repeat (8) @(posedge CLK);
    rst <= 1'b0;
    @(posedge CLK);
    assert ({dut_flags, dut_en, ROM_ADDR, awready, wready, arready, bvalid, rvalid} == '0)
      else begin
        errors++;
        $display("FAILED at %0t: outputs not low after reset", $time);
      end

    // Reset values, ID, strobes, error responses
    read_check(cart_cfg_pkg::REG_FEATURES, 32'h0000_0000, cart_cfg_pkg::RESP_OKAY);
    read_check(cart_cfg_pkg::REG_ROM_MASK, 32'h00FF_FFFF, cart_cfg_pkg::RESP_OKAY);
    read_check(cart_cfg_pkg::REG_SAVERAM_MASK, 32'h0000_0000, cart_cfg_pkg::RESP_OKAY);
    read_check(cart_cfg_pkg::REG_ID, cart_cfg_pkg::CART_ID, cart_cfg_pkg::RESP_OKAY);
    read_check(4'h6, 32'h0000_0000, cart_cfg_pkg::RESP_SLVERR);
    axi_write(cart_cfg_pkg::REG_ID, 32'h1234_5678, 4'hF);
    read_check(cart_cfg_pkg::REG_ID, cart_cfg_pkg::CART_ID, cart_cfg_pkg::RESP_OKAY);
    axi_write(cart_cfg_pkg::REG_ROM_MASK, 32'h0012_3400, 4'b0010);
    read_check(cart_cfg_pkg::REG_ROM_MASK, 32'h00FF_34FF, cart_cfg_pkg::RESP_OKAY);
    axi_write(cart_cfg_pkg::REG_SAVERAM_MASK, 32'hAB00_0055, 4'b1001);
    read_check(cart_cfg_pkg::REG_SAVERAM_MASK, 32'h0000_0055, cart_cfg_pkg::RESP_OKAY);
    axi_write(cart_cfg_pkg::REG_FEATURES, 32'h0000_1218, 4'b0011);
    read_check(cart_cfg_pkg::REG_FEATURES, 32'h0000_0018, cart_cfg_pkg::RESP_OKAY);
    axi_write(cart_cfg_pkg::REG_FEATURES, 32'h0000_0000, 4'hF);
    axi_write(cart_cfg_pkg::REG_SAVERAM_MASK, 32'h0000_0000, 4'hF);

    // ROM with full and with holed mask
    axi_write(cart_cfg_pkg::REG_ROM_MASK, 32'h00FF_FFFF, 4'hF);
    rom_sweep();
    axi_write(cart_cfg_pkg::REG_ROM_MASK, 32'h001F_7FFF, 4'hF);
    rom_sweep();
    axi_write(cart_cfg_pkg::REG_ROM_MASK, 32'h00FF_FFFF, 4'hF);

    // SaveRAM hit, then ROMSEL high, then enable bit clear
    axi_write(cart_cfg_pkg::REG_SAVERAM_MASK, 32'h0000_FFFF, 4'hF);
    saveram_sweep(1'b0);
    saveram_sweep(1'b1);
    axi_write(cart_cfg_pkg::REG_SAVERAM_MASK, 32'h0000_FFFE, 4'hF);
    saveram_sweep(1'b0);

    // MSU1 and 213F on, then off
    axi_write(cart_cfg_pkg::REG_FEATURES, 32'h0000_0018, 4'hF);
    feature_sweep();
    axi_write(cart_cfg_pkg::REG_FEATURES, 32'h0000_0000, 4'hF);
    feature_sweep();

    for (int i = 0; i < 23; i++) begin
      drive_bus(EDGE_ADDRS[i], 8'h00, 1'b1);
    end

    // Every input changes every cycle
    axi_write(cart_cfg_pkg::REG_FEATURES, 32'h0000_0018, 4'hF);
    axi_write(cart_cfg_pkg::REG_SAVERAM_MASK, 32'h001F_FFFF, 4'hF);
    for (int i = 0; i < 3 * N_RAND; i++) begin
      r  = $random(seed);
      r2 = $random(seed);
      drive_bus(r[23:0], r2[7:0], r2[8]);
    end
    repeat (6) @(posedge CLK);

    $display("Checks complete, error count %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sim.f
snes_pkg.sv
cart_cfg_pkg.sv
snes_bus_sync.sv
address.sv
cart_config_regs.sv
cart_top.sv
tb_cart_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the cart_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_cart_top \
  -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Verification failed" "$LOG"; then
  exit 1
fi
exit 0
